// ==== frv_writeback_top.f ====
frv_wb_pkg.sv
frv_csr_if.sv
frv_trap_if.sv
frv_pipeline_writeback.sv
frv_gpr_file.sv
frv_csr_file.sv
frv_writeback_top.sv
frv_writeback_props.sv
tb_frv_writeback.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_frv_writeback
FILELIST = frv_writeback_top.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_frv_writeback.sv ====
module tb_frv_writeback;

    import frv_wb_pkg::*;

    localparam xword_t MTVEC_RESET = 32'h0000_0100;
    localparam int     WAIT_LIMIT  = 16;                 // Cycles before a stall counts as hung

    localparam fu_t  FU_ALU = fu_t'(1 << P_FU_ALU);
    localparam fu_t  FU_MUL = fu_t'(1 << P_FU_MUL);
    localparam fu_t  FU_LSU = fu_t'(1 << P_FU_LSU);
    localparam fu_t  FU_CFU = fu_t'(1 << P_FU_CFU);
    localparam fu_t  FU_CSR = fu_t'(1 << P_FU_CSR);
    localparam uop_t UOP_LD = uop_t'(1 << LSU_LOAD);
    localparam uop_t UOP_RD = uop_t'(1 << CSR_READ);
    localparam uop_t UOP_WR = uop_t'(1 << CSR_WRITE);

    logic        g_clk;
    logic        g_resetn;
    pc_t         s3_pc;
    logic        s4_valid;
    logic        s4_busy;
    reg_idx_t    s4_rd;
    xword_t      s4_opr_a;
    xword_t      s4_opr_b;
    pc_t         s4_pc;
    uop_t        s4_uop;
    fu_t         s4_fu;
    logic        s4_trap;
    logic [31:0] s4_instr;
    logic        cf_req;
    pc_t         cf_target;
    logic        cf_ack;
    reg_idx_t    fwd_rd;
    xword_t      fwd_wdata;
    logic        fwd_load;
    logic        fwd_csr;
    pc_t         trs_pc;
    logic [31:0] trs_instr;
    logic        trs_valid;
    reg_idx_t    gpr_rs_addr;
    xword_t      gpr_rs_rdata;

    xword_t      ref_gpr [0:31];                        // Model of x0..x31
    xword_t      ref_csr [0:4];                         // mscratch, mtvec, mepc, mcause, mtval

    logic        exp_valid;                             // Instruction presented
    logic        exp_cf;                                // Redirect expected
    logic        exp_csr;                               // CSR access in flight
    pc_t         exp_target;
    logic        exp_wen;
    xword_t      exp_wdata;
    reg_idx_t    exp_rd;
    pc_t         exp_pc;
    logic [31:0] exp_instr;

    int seed;
    int errors;
    int timeouts;
    int issued;                                         // Instructions handed to the stage
    int traced;                                         // trs_valid pulses seen

    frv_writeback_top #(.MTVEC_RESET(MTVEC_RESET)) i_frv_writeback_top (.*);

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    // Reference model
    // --------------------

    function automatic int csr_slot(input csr_addr_t addr);
        case (addr)
            CSR_MSCRATCH: return 0;
            CSR_MTVEC:    return 1;
            CSR_MEPC:     return 2;
            CSR_MCAUSE:   return 3;
            CSR_MTVAL:    return 4;
            default:      return -1;                    // Not implemented
        endcase
    endfunction

    function automatic void predict(input fu_t fu, input uop_t uop, input xword_t a,
                                    input xword_t b, input pc_t link, input logic intr,
                                    output logic wen, output xword_t wdata, output logic cf,
                                    output pc_t target, output xword_t csr_new);
        int     slot;
        xword_t old;
        logic   trap_cpu;
        slot     = csr_slot(b[11:0]);
        old      = '0;
        if (slot >= 0) begin
            old = ref_csr[slot];
        end
        trap_cpu = fu[P_FU_CFU] && (uop == CFU_ECALL || uop == CFU_EBREAK);
        wen      = !intr && (fu[P_FU_ALU] || fu[P_FU_MUL] || (fu[P_FU_LSU] && uop[LSU_LOAD]) ||
                   (fu[P_FU_CSR] && uop[CSR_READ]) ||
                   (fu[P_FU_CFU] && (uop == CFU_JALI || uop == CFU_JALR)));
        wdata    = fu[P_FU_CSR] ? old : (fu[P_FU_CFU] ? link : a);
        csr_new  = !uop[CSR_WRITE] ? old : uop[CSR_SET] ? (old | a) :
                   uop[CSR_CLEAR] ? (old & ~a) : a;
        cf       = intr || (fu[P_FU_CFU] && uop != CFU_NOT_TAKEN);
        if (intr || trap_cpu) begin
            target = {ref_csr[1][31:2], 2'b00};         // Trap vector
        end else if (uop == CFU_MRET) begin
            target = {ref_csr[2][31:2], 2'b00};         // Return address
        end else begin
            target = a;
        end
    endfunction

    task automatic check(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Compare process
    // --------------------

    always @(negedge g_clk) begin
        if (g_resetn && !exp_valid) begin
            check("cf_req", 32'(cf_req), 32'd0);        // Idle stage stays quiet
            check("trs_valid", 32'(trs_valid), 32'd0);
        end else if (g_resetn) begin
            check("cf_req", 32'(cf_req), 32'(exp_cf));
            check("s4_busy", 32'(s4_busy), 32'(exp_cf && !cf_ack));
            check("fwd_load", 32'(fwd_load), 32'd0);
            check("fwd_csr", 32'(fwd_csr), 32'(exp_csr));
            if (exp_cf) begin
                check("cf_target", cf_target, exp_target);
            end
            if (trs_valid) begin
                traced++;
                check("trs_pc", trs_pc, exp_pc);
                check("trs_instr", trs_instr, exp_instr);
                if (exp_wen) begin
                    check("fwd_rd", 32'(fwd_rd), 32'(exp_rd));
                    check("fwd_wdata", fwd_wdata, exp_wdata);
                end
            end
        end
    end

    // Stimulus
    // --------------------

    task automatic issue(input fu_t fu, input uop_t uop, input reg_idx_t rd, input xword_t a,
                         input xword_t b, input logic intr);
        xword_t csr_new;
        int     delay;
        int     cycles;
        int     slot;
        delay = ($random(seed) & 32'h7fff_ffff) % 6;   // Fetch ack latency
        @(posedge g_clk);
        exp_pc    = 32'h0000_1000 + 32'(issued * 4);
        exp_rd    = rd;
        exp_instr = $random(seed);
        exp_csr   = fu[P_FU_CSR] && !intr;              // Interrupt kills the access
        predict(fu, uop, a, b, exp_pc + 4, intr, exp_wen, exp_wdata, exp_cf, exp_target,
                csr_new);
        exp_valid = 1'b1;
        s4_valid    <= 1'b1;
        s4_fu       <= fu;
        s4_uop      <= uop;
        s4_rd       <= rd;
        s4_opr_a    <= a;
        s4_opr_b    <= b;
        s4_trap     <= intr;
        s4_pc       <= exp_pc;
        s3_pc       <= exp_pc + 4;
        s4_instr    <= exp_instr;
        gpr_rs_addr <= rd;                              // Read back after commit
        cf_ack      <= exp_cf && delay == 0;
        issued++;
        cycles = 0;
        @(negedge g_clk);
        while (s4_busy && cycles < WAIT_LIMIT) begin
            @(posedge g_clk);
            cycles++;
            cf_ack <= exp_cf && cycles >= delay;
            @(negedge g_clk);
        end
        if (s4_busy) begin
            $display("Timeout: s4_busy still high after %0d cycles at pc 0x%08h",
                     WAIT_LIMIT, exp_pc);
            timeouts++;
        end
        // Commit to the model
        if (exp_wen && rd != 5'd0) begin
            ref_gpr[rd] = exp_wdata;
        end
        slot = csr_slot(b[11:0]);
        if (fu[P_FU_CSR] && !intr && slot >= 0) begin
            ref_csr[slot] = csr_new;
        end
        if (intr || (fu[P_FU_CFU] && (uop == CFU_ECALL || uop == CFU_EBREAK))) begin
            ref_csr[2] = exp_pc;
            ref_csr[3] = {intr, 25'd0, intr ? TRAP_INT_EXT :
                          (uop == CFU_EBREAK) ? TRAP_BREAKPT : TRAP_ECALLM};
            ref_csr[4] = '0;
        end
        @(posedge g_clk);
        exp_valid = 1'b0;
        s4_valid <= 1'b0;
        cf_ack   <= 1'b0;
        @(negedge g_clk);
        check("gpr_rs_rdata", gpr_rs_rdata, ref_gpr[rd]);
    endtask

    initial begin
        logic [3:0] flags;
        int         kind;
        reg_idx_t   rd_pick;
        seed = 66;
        errors = 0;
        timeouts = 0;
        issued = 0;
        traced = 0;
        exp_valid = 1'b0;
        exp_cf = 1'b0;
        exp_csr = 1'b0;
        g_resetn = 1'b0;
        s3_pc = '0;
        s4_valid = 1'b0;
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_pc = '0;
        s4_uop = '0;
        s4_fu = '0;
        s4_trap = 1'b0;
        s4_instr = '0;
        cf_ack = 1'b0;
        gpr_rs_addr = '0;
        for (int i = 0; i < 32; i++) begin
            ref_gpr[i] = '0;
        end
        ref_csr = '{32'd0, MTVEC_RESET, 32'd0, 32'd0, 32'd0};
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;

        // ALU, MUL, loads and stores
        issue(FU_ALU, '0, 5'd0, 32'hdead_beef, '0, 1'b0);   // x0 ignores writes
        repeat (16) begin
            kind    = ($random(seed) & 32'h7fff_ffff) % 4;
            rd_pick = reg_idx_t'($random(seed));
            case (kind)
                0:       issue(FU_ALU, '0, rd_pick, $random(seed), '0, 1'b0);
                1:       issue(FU_MUL, '0, rd_pick, $random(seed), '0, 1'b0);
                2:       issue(FU_LSU, UOP_LD, rd_pick, $random(seed), '0, 1'b0);
                default: issue(FU_LSU, '0, rd_pick, $random(seed), '0, 1'b0);  // Store
            endcase
        end

        // CSR write/set/clear on mscratch
        repeat (12) begin
            flags = 4'($random(seed));
            issue(FU_CSR, {flags, 1'b0}, reg_idx_t'($random(seed)), $random(seed),
                  {20'd0, CSR_MSCRATCH}, 1'b0);
        end
        issue(FU_CSR, UOP_RD, 5'd10, '0, {20'd0, CSR_MSCRATCH}, 1'b0);
        issue(FU_CSR, UOP_RD | UOP_WR, 5'd11, 32'hffff_ffff, 32'h0000_07ff, 1'b0);

        // Branches and jumps
        issue(FU_CFU, CFU_TAKEN, 5'd0, 32'h0000_2000, '0, 1'b0);
        issue(FU_CFU, CFU_JALI, 5'd1, 32'h0000_3000, '0, 1'b0);
        issue(FU_CFU, CFU_JALR, 5'd5, 32'h0000_4004, '0, 1'b0);
        issue(FU_CFU, CFU_NOT_TAKEN, 5'd0, 32'h0000_5000, '0, 1'b0);

        // Traps, moved vector, return
        issue(FU_CFU, CFU_ECALL, 5'd0, '0, '0, 1'b0);
        issue(FU_CSR, UOP_RD, 5'd6, '0, {20'd0, CSR_MEPC}, 1'b0);
        issue(FU_CSR, UOP_RD, 5'd7, '0, {20'd0, CSR_MCAUSE}, 1'b0);
        issue(FU_CSR, UOP_WR, 5'd0, 32'h0000_0240, {20'd0, CSR_MTVEC}, 1'b0);
        issue(FU_CFU, CFU_EBREAK, 5'd0, '0, '0, 1'b0);
        issue(FU_CSR, UOP_RD, 5'd12, '0, {20'd0, CSR_MCAUSE}, 1'b0);
        issue(FU_CFU, CFU_MRET, 5'd0, '0, '0, 1'b0);

        // External interrupt
        issue(FU_ALU, '0, 5'd3, 32'h0000_1234, '0, 1'b1);
        issue(FU_CSR, UOP_RD, 5'd8, '0, {20'd0, CSR_MCAUSE}, 1'b0);
        issue(FU_CSR, UOP_RD, 5'd9, '0, {20'd0, CSR_MEPC}, 1'b0);

        repeat (2) @(posedge g_clk);
        check("trs_valid count", 32'(traced), 32'(issued));
        $display("Done: %0d instructions, %0d errors, %0d timeouts", issued, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== frv_writeback_props.sv ====
module frv_writeback_props (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              s4_valid,
    input  logic              s4_busy,
    input  logic              cf_req,
    input  frv_wb_pkg::pc_t   cf_target,
    input  logic              cf_ack,
    input  logic              csr_en       // Strobe of the CSR bus
);

    // Redirect held with a fixed target until fetch takes it
    a_req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cf_req && !cf_ack) |=> (cf_req && $stable(cf_target)))
        else $error("cf_req dropped or cf_target moved before cf_ack");

    // Single CSR strobe while the input is stalled
    a_csr_once: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (csr_en && s4_valid && s4_busy) |=> !csr_en)
        else $error("csr.en repeated while the stage was stalled");

    // Only a pending redirect may stall the stage
    a_busy_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_busy |-> cf_req)
        else $error("s4_busy high without cf_req");

endmodule

bind frv_pipeline_writeback frv_writeback_props i_frv_writeback_props (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .s4_valid  (s4_valid),
    .s4_busy   (s4_busy),
    .cf_req    (cf_req),
    .cf_target (cf_target),
    .cf_ack    (cf_ack),
    .csr_en    (csr.en)
);

// ==== frv_writeback_top.sv ====
module frv_writeback_top #(
    parameter frv_wb_pkg::xword_t MTVEC_RESET = 32'h0000_0100  // Trap vector at reset
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  frv_wb_pkg::pc_t      s3_pc,
    input  logic                 s4_valid,
    output logic                 s4_busy,
    input  frv_wb_pkg::reg_idx_t s4_rd,
    input  frv_wb_pkg::xword_t   s4_opr_a,
    input  frv_wb_pkg::xword_t   s4_opr_b,
    input  frv_wb_pkg::pc_t      s4_pc,
    input  frv_wb_pkg::uop_t     s4_uop,
    input  frv_wb_pkg::fu_t      s4_fu,
    input  logic                 s4_trap,
    input  logic [31:0]          s4_instr,
    output logic                 cf_req,
    output frv_wb_pkg::pc_t      cf_target,
    input  logic                 cf_ack,
    output frv_wb_pkg::reg_idx_t fwd_rd,
    output frv_wb_pkg::xword_t   fwd_wdata,
    output logic                 fwd_load,
    output logic                 fwd_csr,
    output frv_wb_pkg::pc_t      trs_pc,
    output logic [31:0]          trs_instr,
    output logic                 trs_valid,
    input  frv_wb_pkg::reg_idx_t gpr_rs_addr,   // Debug read port
    output frv_wb_pkg::xword_t   gpr_rs_rdata
);

    import frv_wb_pkg::*;

    logic     gpr_wen;    // Stage to register file
    reg_idx_t gpr_rd;
    xword_t   gpr_wdata;

    frv_csr_if  csr_bus ();   // Stage to CSR file
    frv_trap_if trap_bus ();  // Trap capture and vectors

    frv_pipeline_writeback i_frv_pipeline_writeback (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s3_pc     (s3_pc),
        .s4_valid  (s4_valid),
        .s4_busy   (s4_busy),
        .s4_rd     (s4_rd),
        .s4_opr_a  (s4_opr_a),
        .s4_opr_b  (s4_opr_b),
        .s4_pc     (s4_pc),
        .s4_uop    (s4_uop),
        .s4_fu     (s4_fu),
        .s4_trap   (s4_trap),
        .s4_instr  (s4_instr),
        .gpr_wen   (gpr_wen),
        .gpr_rd    (gpr_rd),
        .gpr_wdata (gpr_wdata),
        .csr       (csr_bus.wb),
        .trap      (trap_bus.wb),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack),
        .fwd_rd    (fwd_rd),
        .fwd_wdata (fwd_wdata),
        .fwd_load  (fwd_load),
        .fwd_csr   (fwd_csr),
        .trs_pc    (trs_pc),
        .trs_instr (trs_instr),
        .trs_valid (trs_valid)
    );

    frv_gpr_file i_frv_gpr_file (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .wen      (gpr_wen),
        .rd       (gpr_rd),
        .wdata    (gpr_wdata),
        .rs_addr  (gpr_rs_addr),
        .rs_rdata (gpr_rs_rdata)
    );

    frv_csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) i_frv_csr_file (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (csr_bus.csrs),
        .trap     (trap_bus.csrs)
    );

endmodule

// ==== frv_csr_file.sv ====
module frv_csr_file #(
    parameter frv_wb_pkg::xword_t MTVEC_RESET = 32'h0000_0100  // mtvec after reset
) (
    input  logic      g_clk,
    input  logic      g_resetn,
    frv_csr_if.csrs   csr,
    frv_trap_if.csrs  trap
);

    import frv_wb_pkg::*;

    xword_t mscratch;
    xword_t mtvec;
    xword_t mepc;
    xword_t mcause;
    xword_t mtval;

    xword_t wr_value;   // Value after write/set/clear
    logic   wr_en;      // Write strobe from the stage
    logic   trap_any;   // Trap capture this cycle

    // Read mux
    // --------------------

    always_comb begin
        case (csr.addr)
            CSR_MSCRATCH: csr.rdata = mscratch;
            CSR_MTVEC:    csr.rdata = mtvec;
            CSR_MEPC:     csr.rdata = mepc;
            CSR_MCAUSE:   csr.rdata = mcause;
            CSR_MTVAL:    csr.rdata = mtval;
            default:      csr.rdata = '0;       // Unimplemented reads zero
        endcase
    end

    // Write value
    // --------------------

    always_comb begin
        if (csr.set) begin
            wr_value = csr.rdata | csr.wdata;   // Bit set
        end else if (csr.clr) begin
            wr_value = csr.rdata & ~csr.wdata;  // Bit clear
        end else begin
            wr_value = csr.wdata;               // Plain write
        end
    end

    assign wr_en    = csr.en && csr.wr;
    assign trap_any = trap.cpu || trap.intr;

    // Registers
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mtvec    <= MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            if (wr_en && csr.addr == CSR_MSCRATCH) begin
                mscratch <= wr_value;
            end
            if (wr_en && csr.addr == CSR_MTVEC) begin
                mtvec <= wr_value;
            end
            // Trap capture wins over a software write
            if (trap_any) begin
                mepc   <= trap.pc;
                mtval  <= trap.mtval;
                mcause <= '0;
                mcause[MCAUSE_INT]     <= trap.intr;         // Interrupt flag
                mcause[$bits(cause_t)-1:0] <= trap.cause;
            end else begin
                if (wr_en && csr.addr == CSR_MEPC) begin
                    mepc <= wr_value;
                end
                if (wr_en && csr.addr == CSR_MCAUSE) begin
                    mcause <= wr_value;
                end
                if (wr_en && csr.addr == CSR_MTVAL) begin
                    mtval <= wr_value;
                end
            end
        end
    end

    // Exported to fetch, word aligned
    assign trap.mtvec = {mtvec[31:2], 2'b00};
    assign trap.mepc  = {mepc[31:2], 2'b00};

endmodule

// ==== frv_gpr_file.sv ====
module frv_gpr_file (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 wen,       // Write strobe
    input  frv_wb_pkg::reg_idx_t rd,        // Write index
    input  frv_wb_pkg::xword_t   wdata,     // Write data
    input  frv_wb_pkg::reg_idx_t rs_addr,   // Read index
    output frv_wb_pkg::xword_t   rs_rdata   // Read data, combinational
);

    import frv_wb_pkg::*;

    xword_t regs [31:1];  // x0 has no storage

    // Write port
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                  // Clear all
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;                  // Drop writes to x0
        end
    end

    // Read port
    // --------------------

    always_comb begin
        if (rs_addr == '0) begin
            rs_rdata = '0;                      // Hard-wired zero
        end else begin
            rs_rdata = regs[rs_addr];
        end
    end

endmodule

// ==== frv_pipeline_writeback.sv ====
module frv_pipeline_writeback (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  frv_wb_pkg::pc_t      s3_pc,      // Next PC, link value for JAL/JALR
    input  logic                 s4_valid,
    output logic                 s4_busy,
    input  frv_wb_pkg::reg_idx_t s4_rd,
    input  frv_wb_pkg::xword_t   s4_opr_a,   // Result or jump target
    input  frv_wb_pkg::xword_t   s4_opr_b,   // CSR address in low bits
    input  frv_wb_pkg::pc_t      s4_pc,
    input  frv_wb_pkg::uop_t     s4_uop,
    input  frv_wb_pkg::fu_t      s4_fu,
    input  logic                 s4_trap,    // Interrupt taken on this instruction
    input  logic [31:0]          s4_instr,
    output logic                 gpr_wen,
    output frv_wb_pkg::reg_idx_t gpr_rd,
    output frv_wb_pkg::xword_t   gpr_wdata,
    frv_csr_if.wb                csr,
    frv_trap_if.wb               trap,
    output logic                 cf_req,
    output frv_wb_pkg::pc_t      cf_target,
    input  logic                 cf_ack,
    output frv_wb_pkg::reg_idx_t fwd_rd,
    output frv_wb_pkg::xword_t   fwd_wdata,
    output logic                 fwd_load,
    output logic                 fwd_csr,
    output frv_wb_pkg::pc_t      trs_pc,
    output logic [31:0]          trs_instr,
    output logic                 trs_valid
);

    import frv_wb_pkg::*;

    logic pipe_progress;  // Instruction consumed this cycle
    logic exec;           // Valid and not interrupted
    logic int_trap;       // Valid and interrupted
    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic csr_done;       // Strobe already issued, input stalled
    logic csr_gpr_wen;
    logic cfu_taken, cfu_link, cfu_ecall, cfu_ebreak, cfu_trap, cfu_mret;
    logic cf_any;         // Instruction needs a fetch redirect
    logic cf_finish;      // Redirect acknowledged this cycle
    logic cfu_done;       // Redirect acknowledged, input stalled

    assign pipe_progress = s4_valid && !s4_busy;
    assign exec          = s4_valid && !s4_trap;
    assign int_trap      = s4_valid && s4_trap;

    // Decode
    // --------------------

    assign fu_alu = exec && s4_fu[P_FU_ALU];
    assign fu_mul = exec && s4_fu[P_FU_MUL];
    assign fu_lsu = exec && s4_fu[P_FU_LSU];
    assign fu_cfu = exec && s4_fu[P_FU_CFU];
    assign fu_csr = exec && s4_fu[P_FU_CSR];

    // CSR sequencing
    // --------------------

    assign csr.en    = fu_csr && !csr_done;            // First cycle only
    assign csr.wr    = fu_csr && s4_uop[CSR_WRITE];
    assign csr.set   = fu_csr && s4_uop[CSR_SET];
    assign csr.clr   = fu_csr && s4_uop[CSR_CLEAR];
    assign csr.addr  = s4_opr_b[11:0];
    assign csr.wdata = s4_opr_a;

    assign csr_gpr_wen = fu_csr && s4_uop[CSR_READ] && !csr_done;  // Old value once

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !pipe_progress && (csr_done || csr.en);  // Hold while stalled
        end
    end

    // Control flow
    // --------------------

    assign cfu_taken  = fu_cfu && (s4_uop == CFU_TAKEN || s4_uop == CFU_JALI ||
                                   s4_uop == CFU_JALR);
    assign cfu_link   = fu_cfu && (s4_uop == CFU_JALI || s4_uop == CFU_JALR);
    assign cfu_ecall  = fu_cfu && (s4_uop == CFU_ECALL);
    assign cfu_ebreak = fu_cfu && (s4_uop == CFU_EBREAK);
    assign cfu_trap   = cfu_ecall || cfu_ebreak;
    assign cfu_mret   = fu_cfu && (s4_uop == CFU_MRET);

    assign cf_any    = cfu_taken || cfu_trap || cfu_mret || int_trap;
    assign cf_req    = cf_any && !cfu_done;             // Held until ack
    assign cf_finish = cf_req && cf_ack;
    assign s4_busy   = cf_any && !(cfu_done || cf_finish);

    always_comb begin
        if (int_trap || cfu_trap) begin
            cf_target = trap.mtvec;                     // Trap entry
        end else if (cfu_mret) begin
            cf_target = trap.mepc;                      // Trap return
        end else if (cfu_taken) begin
            cf_target = s4_opr_a;                       // Branch or jump
        end else begin
            cf_target = '0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || cf_finish);
        end
    end

    // GPR writeback and forwarding
    // --------------------

    assign gpr_rd  = s4_rd;
    assign gpr_wen = fu_alu || fu_mul || (fu_lsu && s4_uop[LSU_LOAD]) ||
                     csr_gpr_wen || cfu_link;

    always_comb begin
        if (csr_gpr_wen) begin
            gpr_wdata = csr.rdata;                      // Old CSR value
        end else if (cfu_link) begin
            gpr_wdata = s3_pc;                          // Return address
        end else begin
            gpr_wdata = s4_opr_a;                       // ALU, MUL, load data
        end
    end

    assign fwd_rd    = gpr_rd;
    assign fwd_wdata = gpr_wdata;
    assign fwd_load  = 1'b0;                            // Loads finish in stage 3
    assign fwd_csr   = fu_csr;

    // Traps
    // --------------------

    // Pulse on the ack so the CSR file captures each trap once
    assign trap.cpu   = cfu_trap && cf_finish;
    assign trap.intr  = int_trap && cf_finish;
    assign trap.cause = int_trap   ? TRAP_INT_EXT :
                        cfu_ebreak ? TRAP_BREAKPT :
                        cfu_ecall  ? TRAP_ECALLM  : '0;
    assign trap.mtval = '0;
    assign trap.pc    = s4_pc;

    // Trace
    // --------------------

    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = pipe_progress;                   // One pulse per instruction

endmodule

// ==== frv_trap_if.sv ====
interface frv_trap_if;

    import frv_wb_pkg::*;

    logic   cpu;    // Trap from ecall or ebreak, acknowledge cycle only
    logic   intr;   // Trap from an interrupt, acknowledge cycle only
    cause_t cause;  // Cause code without the interrupt flag
    xword_t mtval;  // Value captured into mtval
    pc_t    pc;     // PC captured into mepc
    xword_t mtvec;  // Trap vector, word aligned
    xword_t mepc;   // Return address, word aligned

    // Writeback stage side
    modport wb (output cpu, intr, cause, mtval, pc, input mtvec, mepc);

    // CSR file side
    modport csrs (input cpu, intr, cause, mtval, pc, output mtvec, mepc);

endinterface

// ==== frv_csr_if.sv ====
interface frv_csr_if;

    import frv_wb_pkg::*;

    logic      en;     // One access strobe per CSR instruction
    logic      wr;     // Write requested
    logic      set;    // Write as bit set
    logic      clr;    // Write as bit clear
    csr_addr_t addr;   // CSR being accessed
    xword_t    wdata;  // Write operand
    xword_t    rdata;  // Old CSR value, combinational

    // Writeback stage side
    modport wb (output en, wr, set, clr, addr, wdata, input rdata);

    // CSR file side
    modport csrs (input en, wr, set, clr, addr, wdata, output rdata);

endinterface

// ==== frv_wb_pkg.sv ====
package frv_wb_pkg;

    // Widths with a meaning
    // --------------------

    typedef logic [31:0] xword_t;     // Operand, GPR and CSR data word
    typedef logic [31:0] pc_t;        // Program counter
    typedef logic [ 4:0] reg_idx_t;   // GPR index
    typedef logic [11:0] csr_addr_t;  // CSR address
    typedef logic [ 5:0] cause_t;     // Trap cause code, interrupt flag kept apart
    typedef logic [ 4:0] uop_t;       // Micro-op code
    typedef logic [ 4:0] fu_t;        // One-hot functional unit select

    // Functional unit positions
    // --------------------

    localparam int P_FU_ALU = 0;      // Integer ALU
    localparam int P_FU_MUL = 1;      // Multiplier, result already in opr_a
    localparam int P_FU_LSU = 2;      // Load/store unit
    localparam int P_FU_CFU = 3;      // Control flow unit
    localparam int P_FU_CSR = 4;      // CSR access unit

    // Micro-op fields
    // --------------------

    localparam int LSU_LOAD = 3;      // Set for loads, clear for stores

    // CSR flag bits, may combine
    localparam int CSR_READ  = 4;     // Old value goes to rd
    localparam int CSR_WRITE = 3;     // Update the CSR
    localparam int CSR_SET   = 2;     // Update is OR with wdata
    localparam int CSR_CLEAR = 1;     // Update is AND-NOT with wdata

    // Control flow codes, compared as whole uop values
    localparam uop_t CFU_TAKEN     = 5'd1;  // Branch taken
    localparam uop_t CFU_NOT_TAKEN = 5'd2;  // Branch falls through
    localparam uop_t CFU_JALI      = 5'd3;  // JAL
    localparam uop_t CFU_JALR      = 5'd4;  // JALR
    localparam uop_t CFU_ECALL     = 5'd5;  // Environment call
    localparam uop_t CFU_EBREAK    = 5'd6;  // Breakpoint
    localparam uop_t CFU_MRET      = 5'd7;  // Return from machine trap

    // Machine CSR addresses
    // --------------------

    localparam csr_addr_t CSR_MTVEC    = 12'h305;  // Trap vector base
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;  // Scratch register
    localparam csr_addr_t CSR_MEPC     = 12'h341;  // Trap return PC
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;  // Trap cause
    localparam csr_addr_t CSR_MTVAL    = 12'h343;  // Trap value

    // Trap causes
    // --------------------

    localparam cause_t TRAP_BREAKPT = 6'd3;   // ebreak
    localparam cause_t TRAP_ECALLM  = 6'd11;  // ecall from M-mode
    localparam cause_t TRAP_INT_EXT = 6'd11;  // External interrupt, intr set

    // Bit of mcause that flags an interrupt
    localparam int MCAUSE_INT = 31;

endpackage
